/* all.f */
verilog/exu_dec_pkg.sv
verilog/exu_pipe_pkg.sv
verilog/exu_slice_reg.sv
verilog/exu_dispatch.sv
verilog/exu_alu.sv
verilog/exu_bru.sv
verilog/exu_commit.sv
verilog/exu_top.sv
verification/exu_top_props.sv
verification/tb_exu_top.sv

/* run.sh */
#!/bin/sh
# Build and run the execute slice testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_exu_top -f all.f -o tb_exu_top \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_exu_top > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation failed"; exit 1; }
echo "simulation passed"

/* verification/exu_top_props.sv */
/* Concurrent assertions on the execute slice ports
   Reset idle, handshake hold, redirect and x0 write rules */
`timescale 1ns/1ps

module exu_top_props (
    input logic                     clk_i,
    input logic                     arst_n_i,
    input logic                     issue_valid_i,
    input logic                     issue_ready_o,
    input exu_pipe_pkg::exu_issue_t issue_i,
    input logic                     wb_valid_o,
    input logic                     wb_ready_i,
    input exu_pipe_pkg::exu_wb_t    wb_o
);

    a_reset_idle: assert property (@(posedge clk_i) !arst_n_i |-> !wb_valid_o)
        else $error("wb_valid_o high during reset");

    a_issue_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        issue_valid_i && !issue_ready_o |=> issue_valid_i && $stable(issue_i))
        else $error("issue payload changed while stalled");

    a_wb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o))
        else $error("writeback payload changed while stalled");

    a_no_stray_pc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_valid_o && !wb_o.redirect |-> wb_o.redirect_pc == '0)
        else $error("redirect_pc nonzero without redirect");

    a_x0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_valid_o |-> !(wb_o.rd_we && (wb_o.rd_addr == '0)))
        else $error("write enabled for x0");

endmodule

bind exu_top exu_top_props props (.*);

/* verification/tb_exu_top.sv */
/* Table-driven testbench of the execute slice
   Stimulus table, reference model, scoreboard, compare tasks, watchdog */
`timescale 1ns/1ps

module tb_exu_top;

    typedef exu_pipe_pkg::exu_issue_t issue_t;
    typedef exu_pipe_pkg::exu_wb_t    wb_t;

    logic    clk_i = 1'b0;
    logic    arst_n_i;
    logic    issue_valid_i;
    logic    issue_ready_o;
    issue_t  issue_i;
    logic    wb_valid_o;
    logic    wb_ready_i;
    wb_t     wb_o;

    issue_t  tbl[$];             // Stimulus rows
    wb_t     exp_tbl[$];         // Expected result per row
    wb_t     exp_q[$];           // Outstanding results, issue order
    int      acc_q[$];           // Cycle of the issue handshake
    int      cyc = 0;
    int      errors = 0;
    int      checks = 0;
    int      xfers = 0;
    int      tests = 0;
    bit      lat_chk = 1'b1;     // Latency check while ready is held high
    bit      rand_ready = 1'b0;  // Random back-pressure on writeback
    realtime wd_limit = 0.0;

    exu_top dut (.*);

    always #2 clk_i = !clk_i;  // 4 ns period

    always @(posedge clk_i) cyc <= cyc + 1;

    always @(posedge clk_i) begin
        #1;
        wb_ready_i = rand_ready ? 1'($urandom) : 1'b1;
    end

    // RV32I result of one instruction
    function automatic wb_t model(input issue_t t);
        wb_t         w;
        logic [31:0] b;
        w         = '0;
        w.rd_addr = t.rd_addr;
        w.inst_id = t.inst_id;
        b         = t.dec.op2_imm ? t.imm : t.rs2_data;  // Second source
        if (t.dec.grp == exu_dec_pkg::GRP_ALU) begin
            w.rd_we = 1'b1;
            case (t.dec.alu_op)
                exu_dec_pkg::ALU_ADD:   w.rd_data = t.rs1_data + b;
                exu_dec_pkg::ALU_SUB:   w.rd_data = t.rs1_data - b;
                exu_dec_pkg::ALU_SLL:   w.rd_data = t.rs1_data << b[4:0];
                exu_dec_pkg::ALU_SLT:   w.rd_data = 32'($signed(t.rs1_data) < $signed(b));
                exu_dec_pkg::ALU_SLTU:  w.rd_data = 32'(t.rs1_data < b);
                exu_dec_pkg::ALU_XOR:   w.rd_data = t.rs1_data ^ b;
                exu_dec_pkg::ALU_SRL:   w.rd_data = t.rs1_data >> b[4:0];
                exu_dec_pkg::ALU_SRA:   w.rd_data = 32'($signed(t.rs1_data) >>> b[4:0]);
                exu_dec_pkg::ALU_OR:    w.rd_data = t.rs1_data | b;
                exu_dec_pkg::ALU_AND:   w.rd_data = t.rs1_data & b;
                exu_dec_pkg::ALU_LUI:   w.rd_data = t.imm;
                exu_dec_pkg::ALU_AUIPC: w.rd_data = t.pc + t.imm;
                default:                w.rd_data = '0;
            endcase
        end else if (t.dec.grp == exu_dec_pkg::GRP_BJP) begin
            case (t.dec.bjp_op)
                exu_dec_pkg::BJP_BEQ:  w.redirect = t.rs1_data == t.rs2_data;
                exu_dec_pkg::BJP_BNE:  w.redirect = t.rs1_data != t.rs2_data;
                exu_dec_pkg::BJP_BLT:  w.redirect = $signed(t.rs1_data) < $signed(t.rs2_data);
                exu_dec_pkg::BJP_BGE:  w.redirect = $signed(t.rs1_data) >= $signed(t.rs2_data);
                exu_dec_pkg::BJP_BLTU: w.redirect = t.rs1_data < t.rs2_data;
                exu_dec_pkg::BJP_BGEU: w.redirect = t.rs1_data >= t.rs2_data;
                default: begin  // JAL, JALR link and jump
                    w.redirect = 1'b1;
                    w.rd_we    = 1'b1;
                    w.rd_data  = t.pc + 32'd4;
                end
            endcase
            w.redirect_pc = (t.dec.bjp_op == exu_dec_pkg::BJP_JALR)
                            ? ((t.rs1_data + t.imm) & ~32'd1) : (t.pc + t.imm);
        end else if (t.dec.sys_op == exu_dec_pkg::SYS_FENCE) begin
            w.redirect    = 1'b1;
            w.redirect_pc = t.pc + 32'd4;  // Refetch
        end
        if (!w.redirect) w.redirect_pc = '0;
        if (w.rd_addr == '0) w.rd_we = 1'b0;  // x0 stays zero
        if (!w.rd_we) w.rd_data = '0;
        return w;
    endfunction

    function automatic logic [31:0] imm12();  // Sign extended 12 bit immediate
        return 32'($signed(12'($urandom)));
    endfunction

    function automatic logic [4:0] pick_rd();  // Every fifth row targets x0
        return (tbl.size() % 5 == 2) ? 5'd0 : 5'($urandom_range(31, 1));
    endfunction

    task automatic add_row(input exu_dec_pkg::exu_grp_e grp, input logic [3:0] aop,
                           input logic imm_f, input logic [2:0] bop, input logic sop,
                           input logic [31:0] imm, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [4:0] rd);
        issue_t t;
        t              = '0;
        t.dec.grp      = grp;
        t.dec.alu_op   = exu_dec_pkg::alu_op_e'(aop);
        t.dec.op1_pc   = (grp == exu_dec_pkg::GRP_ALU) && (aop == exu_dec_pkg::ALU_AUIPC);
        t.dec.op1_zero = (grp == exu_dec_pkg::GRP_ALU) && (aop == exu_dec_pkg::ALU_LUI);
        t.dec.op2_imm  = imm_f || t.dec.op1_pc || t.dec.op1_zero;
        t.dec.bjp_op   = exu_dec_pkg::bjp_op_e'(bop);
        t.dec.sys_op   = exu_dec_pkg::sys_op_e'(sop);
        t.pc           = $urandom & 32'hffff_fffc;  // Word aligned
        t.imm          = imm;
        t.rs1_data     = rs1;
        t.rs2_data     = rs2;
        t.rd_addr      = rd;
        t.inst_id      = 2'(tbl.size());
        tbl.push_back(t);
        exp_tbl.push_back(model(t));
    endtask

    task automatic build_table();
        logic [31:0] v;
        logic [31:0] lhs;
        logic [31:0] rhs;
        for (int op = 0; op < 12; op++) begin  // Register and immediate forms
            for (int f = 0; f < 2; f++) begin
                add_row(exu_dec_pkg::GRP_ALU, 4'(op), 1'(f), 3'd0, 1'b0, imm12(),
                        $urandom, $urandom, pick_rd());
            end
        end
        // Sign boundary for compares and arithmetic shift
        add_row(exu_dec_pkg::GRP_ALU, exu_dec_pkg::ALU_SLT, 1'b0, 3'd0, 1'b0, 0,
                32'hffff_fff0, 32'h5, 5'd3);
        add_row(exu_dec_pkg::GRP_ALU, exu_dec_pkg::ALU_SLTU, 1'b0, 3'd0, 1'b0, 0,
                32'hffff_fff0, 32'h5, 5'd4);
        add_row(exu_dec_pkg::GRP_ALU, exu_dec_pkg::ALU_SRA, 1'b1, 3'd0, 1'b0, 32'h7,
                32'h8000_1234, 0, 5'd5);
        for (int op = 2; op < 8; op++) begin  // Equal pair and both sign orders
            for (int k = 0; k < 3; k++) begin
                v   = $urandom;
                lhs = (k == 0) ? v : ((k == 1) ? 32'hffff_fff0 : 32'h5);
                rhs = (k == 0) ? v : ((k == 1) ? 32'h5 : 32'hffff_fff0);
                add_row(exu_dec_pkg::GRP_BJP, 4'd0, 1'b0, 3'(op), 1'b0, imm12() & ~32'd1,
                        lhs, rhs, pick_rd());
            end
        end
        add_row(exu_dec_pkg::GRP_BJP, 4'd0, 1'b0, exu_dec_pkg::BJP_JAL, 1'b0,
                imm12() & ~32'd1, $urandom, $urandom, 5'd1);
        add_row(exu_dec_pkg::GRP_BJP, 4'd0, 1'b0, exu_dec_pkg::BJP_JAL, 1'b0,
                imm12() & ~32'd1, $urandom, $urandom, 5'd0);
        add_row(exu_dec_pkg::GRP_BJP, 4'd0, 1'b0, exu_dec_pkg::BJP_JALR, 1'b0,
                imm12() & ~32'd1, $urandom | 32'd1, $urandom, 5'd9);  // Odd sum
        add_row(exu_dec_pkg::GRP_SYS, 4'd0, 1'b0, 3'd0, exu_dec_pkg::SYS_NOP, 0, 0, 0, 5'd7);
        add_row(exu_dec_pkg::GRP_SYS, 4'd0, 1'b0, 3'd0, exu_dec_pkg::SYS_FENCE, 0, 0, 0, 5'd0);
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            if (got.rd_we !== exp.rd_we)
                $display("mismatch wb_o.rd_we got %h exp %h", got.rd_we, exp.rd_we);
            if (got.rd_addr !== exp.rd_addr)
                $display("mismatch wb_o.rd_addr got %h exp %h", got.rd_addr, exp.rd_addr);
            if (got.rd_data !== exp.rd_data)
                $display("mismatch wb_o.rd_data got %h exp %h", got.rd_data, exp.rd_data);
            if (got.redirect !== exp.redirect)
                $display("mismatch wb_o.redirect got %h exp %h", got.redirect, exp.redirect);
            if (got.redirect_pc !== exp.redirect_pc)
                $display("mismatch wb_o.redirect_pc got %h exp %h", got.redirect_pc,
                         exp.redirect_pc);
            if (got.inst_id !== exp.inst_id)
                $display("mismatch wb_o.inst_id got %h exp %h", got.inst_id, exp.inst_id);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch %s transfer count got %h exp %h", name, got, exp);
        end
    endtask

    // Issue one row and hold it until accepted
    task automatic send(input int idx);
        issue_valid_i = 1'b1;
        issue_i       = tbl[idx];
        do @(negedge clk_i); while (!issue_ready_o);
        exp_q.push_back(exp_tbl[idx]);
        acc_q.push_back(cyc);
        @(posedge clk_i);
        #1;
        issue_valid_i = 1'b0;
    endtask

    task automatic run_phase(input string name, input bit rnd);
        int err0;
        int x0;
        err0       = errors;
        x0         = xfers;
        rand_ready = rnd;
        lat_chk    = !rnd;
        @(posedge clk_i);
        #1;
        foreach (tbl[i]) begin
            if (rnd && $urandom_range(1, 0) == 1) begin  // Idle gap on issue
                @(posedge clk_i);
                #1;
            end
            send(i);
        end
        while (exp_q.size() != 0) @(negedge clk_i);  // Wait for every outstanding result
        repeat (4) @(negedge clk_i);  // Late duplicates still counted
        check_count(name, xfers - x0, tbl.size());
        tests++;
        $display("test %s: %0d transfers, %s", name, xfers - x0,
                 (errors == err0) ? "ok" : "failed");
    endtask

    // Writeback monitor and scoreboard
    always @(negedge clk_i) begin
        int acc;
        if (arst_n_i && wb_valid_o && wb_ready_i) begin
            xfers++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("writeback id %h arrived with nothing outstanding", wb_o.inst_id);
            end else begin
                acc = acc_q.pop_front();
                check_wb(wb_o, exp_q.pop_front());
                if (lat_chk && (cyc != acc + 2)) begin
                    errors++;
                    $display("result id %h left at cycle %0d instead of %0d",
                             wb_o.inst_id, cyc, acc + 2);
                end
            end
        end
    end

    initial begin
        wait (wd_limit > 0.0);
        #(wd_limit);
        $display("watchdog expired at %0t, writeback results still missing", $realtime);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int err0;
        void'($urandom(37700));
        arst_n_i      = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        wb_ready_i    = 1'b1;
        build_table();
        wd_limit = (tbl.size() * 2 * 20 + 10) * 4.0;  // Both passes plus reset time in ns
        repeat (10) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        err0     = errors;
        repeat (4) begin  // Idle slice after reset
            @(negedge clk_i);
            checks++;
            if (wb_valid_o !== 1'b0 || issue_ready_o !== 1'b1) begin
                errors++;
                $display("slice not idle after reset, wb_valid_o or issue_ready_o wrong");
            end
        end
        tests++;
        $display("test reset_idle: %s", (errors == err0) ? "ok" : "failed");
        run_phase("ready_high", 1'b0);
        run_phase("backpressure", 1'b1);
        $display("tests %0d, checks %0d, transfers %0d, errors %0d", tests, checks, xfers,
                 errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog/exu_alu.sv */
/* RV32I integer ALU, combinational
   Arithmetic, logic, shifts, compares, LUI, AUIPC and link value */
`timescale 1ns/1ps

module exu_alu (
    input  exu_pipe_pkg::alu_req_t req_i,
    output exu_pipe_pkg::alu_res_t res_o
);

    logic [4:0]                    shamt;   // Shift amount
    logic                          lt_s;    // Signed less than
    logic                          lt_u;    // Unsigned less than
    logic [exu_pipe_pkg::XLEN-1:0] result;

    assign shamt = req_i.op2[4:0];
    assign lt_s  = $signed(req_i.op1) < $signed(req_i.op2);
    assign lt_u  = req_i.op1 < req_i.op2;

    always_comb begin
        case (req_i.op)
            exu_dec_pkg::ALU_ADD:   result = req_i.op1 + req_i.op2;
            exu_dec_pkg::ALU_SUB:   result = req_i.op1 - req_i.op2;
            exu_dec_pkg::ALU_SLL:   result = req_i.op1 << shamt;
            exu_dec_pkg::ALU_SLT:   result = {{(exu_pipe_pkg::XLEN-1){1'b0}}, lt_s};
            exu_dec_pkg::ALU_SLTU:  result = {{(exu_pipe_pkg::XLEN-1){1'b0}}, lt_u};
            exu_dec_pkg::ALU_XOR:   result = req_i.op1 ^ req_i.op2;
            exu_dec_pkg::ALU_SRL:   result = req_i.op1 >> shamt;
            exu_dec_pkg::ALU_SRA:   result = $signed(req_i.op1) >>> shamt;  // Sign fill
            exu_dec_pkg::ALU_OR:    result = req_i.op1 | req_i.op2;
            exu_dec_pkg::ALU_AND:   result = req_i.op1 & req_i.op2;
            exu_dec_pkg::ALU_LUI:   result = req_i.op1 + req_i.op2;  // op1 is zero
            exu_dec_pkg::ALU_AUIPC: result = req_i.op1 + req_i.op2;  // op1 is pc
            default:                result = '0;                     // Unused codes
        endcase
    end

    assign res_o.wb_en = req_i.req && req_i.wb_en;  // No write without a request
    assign res_o.data  = result;

endmodule

/* verilog/exu_bru.sv */
/* Branch and jump unit, combinational
   Compare, taken decision and redirect target for branches, jumps, FENCE */
`timescale 1ns/1ps

module exu_bru (
    input  exu_pipe_pkg::bru_req_t req_i,
    output exu_pipe_pkg::bru_res_t res_o
);

    logic                          eq;     // Operands equal
    logic                          lt_s;   // Signed less than
    logic                          lt_u;   // Unsigned less than
    logic                          taken;  // Redirect condition
    logic [exu_pipe_pkg::XLEN-1:0] sum;    // Raw target

    assign eq   = req_i.cmp1 == req_i.cmp2;
    assign lt_s = $signed(req_i.cmp1) < $signed(req_i.cmp2);
    assign lt_u = req_i.cmp1 < req_i.cmp2;
    assign sum  = req_i.tgt1 + req_i.tgt2;

    always_comb begin
        if (req_i.fence) begin
            taken = 1'b1;  // Always refetch
        end else begin
            case (req_i.op)
                exu_dec_pkg::BJP_JAL:  taken = 1'b1;
                exu_dec_pkg::BJP_JALR: taken = 1'b1;
                exu_dec_pkg::BJP_BEQ:  taken = eq;
                exu_dec_pkg::BJP_BNE:  taken = !eq;
                exu_dec_pkg::BJP_BLT:  taken = lt_s;
                exu_dec_pkg::BJP_BGE:  taken = !lt_s;
                exu_dec_pkg::BJP_BLTU: taken = lt_u;
                default:               taken = !lt_u;  // BGEU
            endcase
        end
    end

    assign res_o.redirect = req_i.req && taken;

    // JALR clears bit 0 of the target
    always_comb begin
        res_o.target = sum;
        if (!req_i.fence && (req_i.op == exu_dec_pkg::BJP_JALR)) begin
            res_o.target[0] = 1'b0;
        end
    end

endmodule

/* verilog/exu_commit.sv */
/* Commit stage of the execute slice
   Merges ALU and branch results into the writeback record */
`timescale 1ns/1ps

module exu_commit (
    input  exu_pipe_pkg::exu_issue_t issue_i,
    input  exu_pipe_pkg::alu_res_t   alu_res_i,
    input  exu_pipe_pkg::bru_res_t   bru_res_i,
    output exu_pipe_pkg::exu_wb_t    wb_o
);

    logic rd_we;  // Register write after x0 filter

    assign rd_we = alu_res_i.wb_en && (issue_i.rd_addr != '0);  // x0 never written

    always_comb begin
        wb_o         = '0;
        wb_o.rd_we   = rd_we;
        wb_o.rd_addr = issue_i.rd_addr;
        wb_o.inst_id = issue_i.inst_id;  // For the writeback consumer
        if (rd_we) begin
            wb_o.rd_data = alu_res_i.data;
        end
        if (bru_res_i.redirect) begin
            wb_o.redirect    = 1'b1;
            wb_o.redirect_pc = bru_res_i.target;
        end
    end

endmodule

/* verilog/exu_dec_pkg.sv */
/* Decode-side types of the execute slice
   Unit groups, ALU and branch op codes, decode info record */
package exu_dec_pkg;

    // Unit group, zero is the SYS group so an idle record reads as NOP
    typedef enum logic [1:0] {
        GRP_SYS = 2'd0,  // NOP and FENCE
        GRP_ALU = 2'd1,  // Register and immediate arithmetic
        GRP_BJP = 2'd2   // Branches and jumps
    } exu_grp_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,   // Also used for the link value
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,   // Signed compare
        ALU_SLTU  = 4'd4,   // Unsigned compare
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,   // Arithmetic shift
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_LUI   = 4'd10,  // op1 forced to zero
        ALU_AUIPC = 4'd11   // op1 forced to pc
    } alu_op_e;

    typedef enum logic [2:0] {
        BJP_JAL  = 3'd0,
        BJP_JALR = 3'd1,  // Target base is rs1
        BJP_BEQ  = 3'd2,
        BJP_BNE  = 3'd3,
        BJP_BLT  = 3'd4,
        BJP_BGE  = 3'd5,
        BJP_BLTU = 3'd6,
        BJP_BGEU = 3'd7
    } bjp_op_e;

    typedef enum logic {
        SYS_NOP   = 1'b0,
        SYS_FENCE = 1'b1  // Refetch from pc plus 4
    } sys_op_e;

    typedef struct packed {
        exu_grp_e grp;       // Target unit group
        alu_op_e  alu_op;    // ALU operation
        logic     op1_pc;    // Set for AUIPC
        logic     op1_zero;  // Set for LUI
        logic     op2_imm;   // I-type, LUI and AUIPC
        bjp_op_e  bjp_op;    // Branch or jump kind
        sys_op_e  sys_op;    // NOP or FENCE
    } dec_info_t;

endpackage

/* verilog/exu_dispatch.sv */
/* Operand dispatcher of the execute slice
   Builds ALU and branch unit requests from the issue record */
`timescale 1ns/1ps

module exu_dispatch (
    input  exu_pipe_pkg::exu_issue_t issue_i,
    input  logic                     issue_valid_i,
    output exu_pipe_pkg::alu_req_t   alu_req_o,
    output exu_pipe_pkg::bru_req_t   bru_req_o
);

    exu_dec_pkg::dec_info_t dec;  // Decode info of the held instruction

    logic op_alu;    // ALU group
    logic op_bjp;    // Branch or jump group
    logic op_jump;   // JAL or JALR
    logic op_jalr;
    logic op_fence;  // SYS group FENCE

    assign dec = issue_i.dec;

    // Unit selection, all gated by valid
    assign op_alu   = issue_valid_i && (dec.grp == exu_dec_pkg::GRP_ALU);
    assign op_bjp   = issue_valid_i && (dec.grp == exu_dec_pkg::GRP_BJP);
    assign op_jalr  = op_bjp && (dec.bjp_op == exu_dec_pkg::BJP_JALR);
    assign op_jump  = op_jalr || (op_bjp && (dec.bjp_op == exu_dec_pkg::BJP_JAL));
    assign op_fence = issue_valid_i && (dec.grp == exu_dec_pkg::GRP_SYS)
                      && (dec.sys_op == exu_dec_pkg::SYS_FENCE);

    // ALU request
    always_comb begin
        alu_req_o = '0;  // Idle when not selected
        if (op_jump) begin
            alu_req_o.req   = 1'b1;
            alu_req_o.wb_en = 1'b1;                   // Link write
            alu_req_o.op1   = issue_i.pc;
            alu_req_o.op2   = exu_pipe_pkg::LINK_OFS;  // pc plus 4
            alu_req_o.op    = exu_dec_pkg::ALU_ADD;
        end else if (op_alu) begin
            alu_req_o.req   = 1'b1;
            alu_req_o.wb_en = 1'b1;
            if (dec.op1_pc) begin
                alu_req_o.op1 = issue_i.pc;        // AUIPC
            end else if (dec.op1_zero) begin
                alu_req_o.op1 = '0;                // LUI
            end else begin
                alu_req_o.op1 = issue_i.rs1_data;
            end
            alu_req_o.op2 = dec.op2_imm ? issue_i.imm : issue_i.rs2_data;
            alu_req_o.op  = dec.alu_op;
        end
    end

    // Branch unit request
    always_comb begin
        bru_req_o = '0;  // Idle when not selected
        if (op_bjp) begin
            bru_req_o.req  = 1'b1;
            bru_req_o.cmp1 = issue_i.rs1_data;
            bru_req_o.cmp2 = issue_i.rs2_data;
            bru_req_o.tgt1 = op_jalr ? issue_i.rs1_data : issue_i.pc;  // JALR base is rs1
            bru_req_o.tgt2 = issue_i.imm;
            bru_req_o.op   = dec.bjp_op;
        end else if (op_fence) begin
            bru_req_o.req   = 1'b1;
            bru_req_o.tgt1  = issue_i.pc;
            bru_req_o.tgt2  = exu_pipe_pkg::LINK_OFS;  // Refetch next instruction
            bru_req_o.fence = 1'b1;
        end
    end

endmodule

/* verilog/exu_pipe_pkg.sv */
/* Pipeline-side types and widths of the execute slice
   Issue record, unit requests and results, writeback record */
package exu_pipe_pkg;

    localparam int XLEN   = 32;  // Data path width
    localparam int REG_AW = 5;   // Register index width
    localparam int ID_W   = 2;   // Instruction id width

    localparam logic [XLEN-1:0] LINK_OFS = 32'd4;  // Link and fence increment

    typedef struct packed {
        exu_dec_pkg::dec_info_t dec;       // Decode info
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        imm;       // Sign extended immediate
        logic [XLEN-1:0]        rs1_data;
        logic [XLEN-1:0]        rs2_data;
        logic [REG_AW-1:0]      rd_addr;
        logic [ID_W-1:0]        inst_id;   // Passed through untouched
    } exu_issue_t;

    typedef struct packed {
        logic                 req;
        logic                 wb_en;  // Result goes to rd
        logic [XLEN-1:0]      op1;
        logic [XLEN-1:0]      op2;
        exu_dec_pkg::alu_op_e op;
    } alu_req_t;

    typedef struct packed {
        logic                 req;
        logic [XLEN-1:0]      cmp1;   // Branch compare operands
        logic [XLEN-1:0]      cmp2;
        logic [XLEN-1:0]      tgt1;   // Target base
        logic [XLEN-1:0]      tgt2;   // Target offset
        exu_dec_pkg::bjp_op_e op;
        logic                 fence;
    } bru_req_t;

    typedef struct packed {
        logic            wb_en;
        logic [XLEN-1:0] data;
    } alu_res_t;

    typedef struct packed {
        logic            redirect;
        logic [XLEN-1:0] target;
    } bru_res_t;

    typedef struct packed {
        logic              rd_we;
        logic [REG_AW-1:0] rd_addr;
        logic [XLEN-1:0]   rd_data;
        logic              redirect;
        logic [XLEN-1:0]   redirect_pc;
        logic [ID_W-1:0]   inst_id;
    } exu_wb_t;

endpackage

/* verilog/exu_slice_reg.sv */
/* One-entry valid/ready pipeline register, full throughput
   Payload type set by parameter */
`timescale 1ns/1ps

module exu_slice_reg #(
    parameter type payload_t = exu_pipe_pkg::exu_issue_t
) (
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;  // Entry occupied
    payload_t data_q;   // Held payload
    logic     xfer_in;  // Input transfer this cycle

    assign in_ready_o = !valid_q || out_ready_i;  // Empty or draining
    assign xfer_in    = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (xfer_in) begin
            valid_q <= 1'b1;  // Refill, possibly same cycle as drain
        end else if (out_ready_i) begin
            valid_q <= 1'b0;  // Drained
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer_in) begin
            data_q <= in_data_i;  // Loads only on a transfer
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

/* verilog/exu_top.sv */
/* Execute slice top level
   Issue register, dispatcher, ALU, branch unit, commit and writeback register */
`timescale 1ns/1ps

module exu_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,

    input  logic                     issue_valid_i,
    output logic                     issue_ready_o,
    input  exu_pipe_pkg::exu_issue_t issue_i,

    output logic                     wb_valid_o,
    input  logic                     wb_ready_i,
    output exu_pipe_pkg::exu_wb_t    wb_o
);

    exu_pipe_pkg::exu_issue_t issue_q;      // Held instruction
    logic                     issue_q_vld;  // Held instruction valid
    logic                     wb_in_rdy;    // Writeback register can take
    exu_pipe_pkg::alu_req_t   alu_req;
    exu_pipe_pkg::bru_req_t   bru_req;
    exu_pipe_pkg::alu_res_t   alu_res;
    exu_pipe_pkg::bru_res_t   bru_res;
    exu_pipe_pkg::exu_wb_t    wb_d;         // Merged result

    exu_slice_reg #(.payload_t(exu_pipe_pkg::exu_issue_t)) issue_reg (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (issue_valid_i),
        .in_ready_o  (issue_ready_o),
        .in_data_i   (issue_i),
        .out_valid_o (issue_q_vld),
        .out_ready_i (wb_in_rdy),   // Back-pressure from writeback
        .out_data_o  (issue_q)
    );

    exu_dispatch u_dispatch (
        .issue_i       (issue_q),
        .issue_valid_i (issue_q_vld),
        .alu_req_o     (alu_req),
        .bru_req_o     (bru_req)
    );

    exu_alu u_alu (
        .req_i (alu_req),
        .res_o (alu_res)
    );

    exu_bru u_bru (
        .req_i (bru_req),
        .res_o (bru_res)
    );

    exu_commit u_commit (
        .issue_i   (issue_q),
        .alu_res_i (alu_res),
        .bru_res_i (bru_res),
        .wb_o      (wb_d)
    );

    exu_slice_reg #(.payload_t(exu_pipe_pkg::exu_wb_t)) wb_reg (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (issue_q_vld),  // Results one edge behind issue
        .in_ready_o  (wb_in_rdy),
        .in_data_i   (wb_d),
        .out_valid_o (wb_valid_o),
        .out_ready_i (wb_ready_i),
        .out_data_o  (wb_o)
    );

endmodule
